// ==== ffn_block.f ====
+incdir+tests
hdl/ffn_pkg.sv
hdl/weight_bank_if.sv
hdl/mac_if.sv
hdl/weight_ram.sv
hdl/weight_bank.sv
hdl/mac_unit.sv
hdl/vector_store.sv
hdl/ffn_sequencer.sv
hdl/ffn_block.sv
tests/ffn_block_tb.sv

// ==== hdl/ffn_block.sv ====
`default_nettype none

module ffn_block (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  wire logic                                      start,
    input  wire logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] x_in,
    input  wire logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] res_in,
    input  wire logic [ffn_pkg::SEL_W-1:0]                 mem_sel,
    input  wire logic                                      mem_wr,
    input  wire logic [ffn_pkg::W_ADDR_W-1:0]              mem_addr,
    input  wire ffn_pkg::data_t                            mem_data,
    output logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0]      data_out,
    output logic                                           output_rdy,
    input  wire logic                                      output_ack,
    output logic                                           done
);

    weight_bank_if wb_bus ();
    mac_if         mac_bus ();

    logic                      host_wr;
    logic                      load;
    ffn_pkg::layer_e           layer;
    logic [ffn_pkg::IDX_W-1:0] col, row, wr_row;
    logic                      layer_end;

    // host writes only land while the block is idle
    assign host_wr        = mem_wr & done;
    assign mac_bus.weight = wb_bus.rdata;

    weight_bank u_bank (
        .clk       (clk),
        .rst       (rst),
        .host_wr   (host_wr),
        .host_sel  (mem_sel),
        .host_addr (mem_addr),
        .host_data (mem_data),
        .rd        (wb_bus.bank)
    );

    mac_unit u_mac (
        .clk (clk),
        .rst (rst),
        .mac (mac_bus.unit)
    );

    vector_store u_store (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .x_in       (x_in),
        .res_in     (res_in),
        .layer      (layer),
        .col        (col),
        .row        (row),
        .mac        (mac_bus.store),
        .wr_row     (wr_row),
        .layer_end  (layer_end),
        .result_vec (data_out)
    );

    ffn_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .output_ack (output_ack),
        .rd         (wb_bus.seq),
        .mac        (mac_bus.seq),
        .load       (load),
        .layer      (layer),
        .col        (col),
        .row        (row),
        .wr_row     (wr_row),
        .layer_end  (layer_end),
        .output_rdy (output_rdy),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== hdl/ffn_pkg.sv ====
`default_nettype none

package ffn_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and dimensions
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W  = 8;
    localparam int ACC_W   = 2 * DATA_W;

    // model and feed-forward vector lengths
    localparam int X_DIM   = 4;
    localparam int XFF_DIM = 8;
    localparam int VEC_MAX = (X_DIM > XFF_DIM) ? X_DIM : XFF_DIM;

    // weights per layer, row-major with one weight per word
    localparam int LIN_DEPTH = X_DIM * X_DIM;
    localparam int FF1_DEPTH = XFF_DIM * X_DIM;
    localparam int FF2_DEPTH = X_DIM * XFF_DIM;

    localparam int W_ADDR_W = $clog2((LIN_DEPTH > FF1_DEPTH) ?
        ((LIN_DEPTH > FF2_DEPTH) ? LIN_DEPTH : FF2_DEPTH) :
        ((FF1_DEPTH > FF2_DEPTH) ? FF1_DEPTH : FF2_DEPTH));
    localparam int IDX_W    = $clog2(VEC_MAX);

    ////////////////////////////////////////////////////////////////////////////
    // host memory select codes
    ////////////////////////////////////////////////////////////////////////////

    localparam int SEL_W = 3;
    localparam logic [SEL_W-1:0] MEM_SEL_LIN = 3'd3;
    localparam logic [SEL_W-1:0] MEM_SEL_FF1 = 3'd4;
    localparam logic [SEL_W-1:0] MEM_SEL_FF2 = 3'd5;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef enum logic [1:0] {
        LAYER_LIN,
        LAYER_FF1,
        LAYER_FF2
    } layer_e;

endpackage

`default_nettype wire

// ==== hdl/ffn_sequencer.sv ====
`default_nettype none

module ffn_sequencer (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start,
    input  wire logic                      output_ack,
    weight_bank_if.seq                     rd,
    mac_if.seq                             mac,
    output logic                           load,
    output ffn_pkg::layer_e                layer,
    output logic [ffn_pkg::IDX_W-1:0]      col,
    output logic [ffn_pkg::IDX_W-1:0]      row,
    output logic [ffn_pkg::IDX_W-1:0]      wr_row,
    output logic                           layer_end,
    output logic                           output_rdy,
    output logic                           done
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN, S_HOLD} state_t;

    state_t                        state;
    logic [ffn_pkg::IDX_W-1:0]     col_cnt, row_cnt;
    logic [ffn_pkg::W_ADDR_W-1:0]  ncols, nrows;
    logic                          last_col, last_row, issue;

    // matrix shape of the current layer
    always_comb begin
        case (layer)
            ffn_pkg::LAYER_LIN: begin
                ncols = ffn_pkg::W_ADDR_W'(ffn_pkg::X_DIM);
                nrows = ffn_pkg::W_ADDR_W'(ffn_pkg::X_DIM);
            end
            ffn_pkg::LAYER_FF1: begin
                ncols = ffn_pkg::W_ADDR_W'(ffn_pkg::X_DIM);
                nrows = ffn_pkg::W_ADDR_W'(ffn_pkg::XFF_DIM);
            end
            default: begin
                ncols = ffn_pkg::W_ADDR_W'(ffn_pkg::XFF_DIM);
                nrows = ffn_pkg::W_ADDR_W'(ffn_pkg::X_DIM);
            end
        endcase
    end

    assign last_col = (col_cnt == ffn_pkg::IDX_W'(ncols - 1'b1));
    assign last_row = (row_cnt == ffn_pkg::IDX_W'(nrows - 1'b1));
    assign issue    = (state == S_RUN);
    assign load     = (state == S_IDLE) && start;

    // one weight read per cycle, row-major address
    assign rd.rd_en = issue;
    assign rd.layer = layer;
    assign rd.addr  = ffn_pkg::W_ADDR_W'(row_cnt) * ncols + ffn_pkg::W_ADDR_W'(col_cnt);

    ////////////////////////////////////////////////////////////////////////////
    // layer, row and column control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            layer      <= ffn_pkg::LAYER_LIN;
            col_cnt    <= '0;
            row_cnt    <= '0;
            layer_end  <= 1'b0;
            output_rdy <= 1'b0;
            done       <= 1'b1;
        end else begin
            layer_end <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_RUN;
                        layer   <= ffn_pkg::LAYER_LIN;
                        col_cnt <= '0;
                        row_cnt <= '0;
                        done    <= 1'b0;
                    end
                end
                S_RUN: begin
                    if (last_col) begin
                        col_cnt <= '0;
                        row_cnt <= last_row ? '0 : row_cnt + 1'b1;
                        if (last_row) begin
                            state <= S_DRAIN;
                        end
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    // last row lands in the buffer before the vectors swap
                    if (layer_end) begin
                        if (layer == ffn_pkg::LAYER_FF2) begin
                            state      <= S_HOLD;
                            output_rdy <= 1'b1;
                            done       <= 1'b1;
                        end else begin
                            state <= S_RUN;
                            layer <= (layer == ffn_pkg::LAYER_LIN) ?
                                     ffn_pkg::LAYER_FF1 : ffn_pkg::LAYER_FF2;
                        end
                    end else if (mac.res_valid) begin
                        layer_end <= 1'b1;
                    end
                end
                default: begin
                    if (output_ack) begin
                        output_rdy <= 1'b0;
                        state      <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // delay line matching the one-cycle read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mac.op_valid <= 1'b0;
            mac.op_first <= 1'b0;
            mac.op_last  <= 1'b0;
            col          <= '0;
            row          <= '0;
            wr_row       <= '0;
        end else begin
            mac.op_valid <= issue;
            mac.op_first <= issue && (col_cnt == '0);
            mac.op_last  <= issue && last_col;
            col          <= col_cnt;
            row          <= row_cnt;
            wr_row       <= row;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mac_if.sv ====
`default_nettype none

interface mac_if;

    // operand beat, aligned with the weight read data
    logic           op_valid;
    logic           op_first;
    logic           op_last;
    ffn_pkg::data_t weight;
    ffn_pkg::data_t act;
    ffn_pkg::data_t residual;

    // one truncated element per row
    logic           res_valid;
    ffn_pkg::data_t result;

    modport seq   (output op_valid, op_first, op_last, input res_valid);

    modport unit  (
        input  op_valid, op_first, op_last, weight, act, residual,
        output res_valid, result
    );

    modport store (output act, residual, input res_valid, result);

endinterface

`default_nettype wire

// ==== hdl/mac_unit.sv ====
`default_nettype none

module mac_unit (
    input  wire logic clk,
    input  wire logic rst,
    mac_if.unit       mac
);

    ffn_pkg::acc_t acc;
    ffn_pkg::acc_t product;
    ffn_pkg::acc_t sum;
    ffn_pkg::acc_t total;

    // both operands sign-extended first, so the product is exact in ACC_W bits
    always_comb begin
        product = ffn_pkg::acc_t'(mac.weight) * ffn_pkg::acc_t'(mac.act);
        sum     = (mac.op_first ? ffn_pkg::acc_t'(0) : acc) + product;
        total   = sum + ffn_pkg::acc_t'(mac.residual);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mac.res_valid <= 1'b0;
        end else begin
            mac.res_valid <= mac.op_valid && mac.op_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulate, then keep the upper half of the wrapped sum
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mac.op_valid) begin
            acc <= sum;
            if (mac.op_last) begin
                mac.result <= total[ffn_pkg::ACC_W-1 -: ffn_pkg::DATA_W];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vector_store.sv ====
`default_nettype none

module vector_store (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire logic                                     load,
    input  wire logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] x_in,
    input  wire logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] res_in,
    input  wire ffn_pkg::layer_e                          layer,
    input  wire logic [ffn_pkg::IDX_W-1:0]                col,
    input  wire logic [ffn_pkg::IDX_W-1:0]                row,
    mac_if.store                                          mac,
    input  wire logic [ffn_pkg::IDX_W-1:0]                wr_row,
    input  wire logic                                     layer_end,
    output logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0]     result_vec
);

    ffn_pkg::data_t act_vec [ffn_pkg::VEC_MAX];
    ffn_pkg::data_t res_vec [ffn_pkg::VEC_MAX];
    ffn_pkg::data_t res_buf [ffn_pkg::VEC_MAX];

    // operand lookup, no residual in the middle layer
    assign mac.act      = act_vec[col];
    assign mac.residual = (layer == ffn_pkg::LAYER_FF1) ? ffn_pkg::data_t'(0) : res_vec[row];

    ////////////////////////////////////////////////////////////////////////////
    // activation and residual vectors
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < ffn_pkg::X_DIM; i++) begin
                act_vec[i] <= x_in[i*ffn_pkg::DATA_W +: ffn_pkg::DATA_W];
                res_vec[i] <= res_in[i*ffn_pkg::DATA_W +: ffn_pkg::DATA_W];
            end
            for (int i = ffn_pkg::X_DIM; i < ffn_pkg::VEC_MAX; i++) begin
                act_vec[i] <= '0;
                res_vec[i] <= '0;
            end
        end else if (layer_end) begin
            act_vec <= res_buf;
            // linear result becomes the FF2 residual
            if (layer == ffn_pkg::LAYER_LIN) begin
                res_vec <= res_buf;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // result buffer, one element per finished row
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ffn_pkg::VEC_MAX; i++) begin
                res_buf[i] <= '0;
            end
        end else if (mac.res_valid) begin
            res_buf[wr_row] <= mac.result;
        end
    end

    always_comb begin
        for (int i = 0; i < ffn_pkg::X_DIM; i++) begin
            result_vec[i*ffn_pkg::DATA_W +: ffn_pkg::DATA_W] = res_buf[i];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/weight_bank.sv ====
`default_nettype none

module weight_bank (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          host_wr,
    input  wire logic [ffn_pkg::SEL_W-1:0]     host_sel,
    input  wire logic [ffn_pkg::W_ADDR_W-1:0]  host_addr,
    input  wire ffn_pkg::data_t                host_data,
    weight_bank_if.bank                        rd
);

    logic            wr_lin, wr_ff1, wr_ff2;
    logic            rd_lin, rd_ff1, rd_ff2;
    ffn_pkg::data_t  q_lin, q_ff1, q_ff2;
    ffn_pkg::layer_e layer_q;

    // host select decode, unknown codes write nothing
    always_comb begin
        wr_lin = 1'b0;
        wr_ff1 = 1'b0;
        wr_ff2 = 1'b0;
        if (host_wr) begin
            case (host_sel)
                ffn_pkg::MEM_SEL_LIN: wr_lin = 1'b1;
                ffn_pkg::MEM_SEL_FF1: wr_ff1 = 1'b1;
                ffn_pkg::MEM_SEL_FF2: wr_ff2 = 1'b1;
                default: ;
            endcase
        end
    end

    assign rd_lin = rd.rd_en && (rd.layer == ffn_pkg::LAYER_LIN);
    assign rd_ff1 = rd.rd_en && (rd.layer == ffn_pkg::LAYER_FF1);
    assign rd_ff2 = rd.rd_en && (rd.layer == ffn_pkg::LAYER_FF2);

    // remember which RAM answers on the next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            layer_q <= ffn_pkg::LAYER_LIN;
        end else if (rd.rd_en) begin
            layer_q <= rd.layer;
        end
    end

    always_comb begin
        case (layer_q)
            ffn_pkg::LAYER_LIN: rd.rdata = q_lin;
            ffn_pkg::LAYER_FF1: rd.rdata = q_ff1;
            default:            rd.rdata = q_ff2;
        endcase
    end

    weight_ram #(.DEPTH(ffn_pkg::LIN_DEPTH)) u_ram_lin (
        .clk     (clk),
        .wr      (wr_lin),
        .wr_addr (host_addr[$clog2(ffn_pkg::LIN_DEPTH)-1:0]),
        .wr_data (host_data),
        .rd_en   (rd_lin),
        .rd_addr (rd.addr[$clog2(ffn_pkg::LIN_DEPTH)-1:0]),
        .rd_data (q_lin)
    );

    weight_ram #(.DEPTH(ffn_pkg::FF1_DEPTH)) u_ram_ff1 (
        .clk     (clk),
        .wr      (wr_ff1),
        .wr_addr (host_addr[$clog2(ffn_pkg::FF1_DEPTH)-1:0]),
        .wr_data (host_data),
        .rd_en   (rd_ff1),
        .rd_addr (rd.addr[$clog2(ffn_pkg::FF1_DEPTH)-1:0]),
        .rd_data (q_ff1)
    );

    weight_ram #(.DEPTH(ffn_pkg::FF2_DEPTH)) u_ram_ff2 (
        .clk     (clk),
        .wr      (wr_ff2),
        .wr_addr (host_addr[$clog2(ffn_pkg::FF2_DEPTH)-1:0]),
        .wr_data (host_data),
        .rd_en   (rd_ff2),
        .rd_addr (rd.addr[$clog2(ffn_pkg::FF2_DEPTH)-1:0]),
        .rd_data (q_ff2)
    );

endmodule

`default_nettype wire

// ==== hdl/weight_bank_if.sv ====
`default_nettype none

interface weight_bank_if;

    logic                            rd_en;
    ffn_pkg::layer_e                 layer;
    logic [ffn_pkg::W_ADDR_W-1:0]    addr;
    // valid one cycle after rd_en
    ffn_pkg::data_t                  rdata;

    modport seq (
        output rd_en, layer, addr,
        input  rdata
    );

    modport bank (
        input  rd_en, layer, addr,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hdl/weight_ram.sv ====
`default_nettype none

module weight_ram #(
    parameter int DEPTH = 16
) (
    input  wire logic                     clk,
    input  wire logic                     wr,
    input  wire logic [$clog2(DEPTH)-1:0] wr_addr,
    input  wire ffn_pkg::data_t           wr_data,
    input  wire logic                     rd_en,
    input  wire logic [$clog2(DEPTH)-1:0] rd_addr,
    output ffn_pkg::data_t                rd_data
);

    ffn_pkg::data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        // output keeps the last word read
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== tests/ffn_model.svh ====
`ifndef FFN_MODEL_SVH
`define FFN_MODEL_SVH

// upper byte of the 16-bit wrapped sum of products and residual
function automatic ffn_pkg::data_t trunc_elem(input int sum, input ffn_pkg::data_t res);
    int total;
    total = sum + int'(res);
    return ffn_pkg::data_t'(total >>> ffn_pkg::DATA_W);
endfunction

// linear, FF1 and FF2 layers on the host copies of weights and vectors
function automatic logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] model_out();
    ffn_pkg::data_t                            lin [ffn_pkg::X_DIM];
    ffn_pkg::data_t                            ff1 [ffn_pkg::XFF_DIM];
    logic [ffn_pkg::X_DIM*ffn_pkg::DATA_W-1:0] out;
    int                                        sum;
    for (int r = 0; r < ffn_pkg::X_DIM; r++) begin
        sum = 0;
        for (int c = 0; c < ffn_pkg::X_DIM; c++) begin
            sum += int'(w_lin[r*ffn_pkg::X_DIM + c]) * int'(x_vec[c]);
        end
        lin[r] = trunc_elem(sum, r_vec[r]);
    end
    // no residual in the middle layer
    for (int r = 0; r < ffn_pkg::XFF_DIM; r++) begin
        sum = 0;
        for (int c = 0; c < ffn_pkg::X_DIM; c++) begin
            sum += int'(w_ff1[r*ffn_pkg::X_DIM + c]) * int'(lin[c]);
        end
        ff1[r] = trunc_elem(sum, ffn_pkg::data_t'(0));
    end
    for (int r = 0; r < ffn_pkg::X_DIM; r++) begin
        sum = 0;
        for (int c = 0; c < ffn_pkg::XFF_DIM; c++) begin
            sum += int'(w_ff2[r*ffn_pkg::XFF_DIM + c]) * int'(ff1[c]);
        end
        out[r*ffn_pkg::DATA_W +: ffn_pkg::DATA_W] = trunc_elem(sum, lin[r]);
    end
    return out;
endfunction

// one host write, called on a falling edge
task automatic write_weight(input logic [ffn_pkg::SEL_W-1:0] sel,
                            input int addr, input ffn_pkg::data_t data);
    mem_wr   = 1'b1;
    mem_sel  = sel;
    mem_addr = ffn_pkg::W_ADDR_W'(addr);
    mem_data = data;
    @(negedge clk);
    mem_wr   = 1'b0;
endtask

task automatic load_weights();
    for (int i = 0; i < ffn_pkg::LIN_DEPTH; i++) begin
        write_weight(ffn_pkg::MEM_SEL_LIN, i, w_lin[i]);
    end
    for (int i = 0; i < ffn_pkg::FF1_DEPTH; i++) begin
        write_weight(ffn_pkg::MEM_SEL_FF1, i, w_ff1[i]);
    end
    for (int i = 0; i < ffn_pkg::FF2_DEPTH; i++) begin
        write_weight(ffn_pkg::MEM_SEL_FF2, i, w_ff2[i]);
    end
endtask

`endif

// ==== tests/ffn_block_tb.sv ====
`default_nettype none

module ffn_block_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VEC_W          = ffn_pkg::X_DIM * ffn_pkg::DATA_W;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int B2B_RUNS       = 6;

    logic                         clk;
    logic                         rst;
    logic                         start;
    logic [VEC_W-1:0]             x_in;
    logic [VEC_W-1:0]             res_in;
    logic [ffn_pkg::SEL_W-1:0]    mem_sel;
    logic                         mem_wr;
    logic [ffn_pkg::W_ADDR_W-1:0] mem_addr;
    ffn_pkg::data_t               mem_data;
    logic [VEC_W-1:0]             data_out;
    logic                         output_rdy;
    logic                         output_ack;
    logic                         done;

    // host copy of the weights and the current vectors
    ffn_pkg::data_t   w_lin [ffn_pkg::LIN_DEPTH];
    ffn_pkg::data_t   w_ff1 [ffn_pkg::FF1_DEPTH];
    ffn_pkg::data_t   w_ff2 [ffn_pkg::FF2_DEPTH];
    ffn_pkg::data_t   x_vec [ffn_pkg::X_DIM];
    ffn_pkg::data_t   r_vec [ffn_pkg::X_DIM];
    logic [VEC_W-1:0] exp_out;

    int value_errors;
    int timeout_errors;

    `include "ffn_model.svh"

    ffn_block DUT (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .x_in       (x_in),
        .res_in     (res_in),
        .mem_sel    (mem_sel),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .data_out   (data_out),
        .output_rdy (output_rdy),
        .output_ack (output_ack),
        .done       (done)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    reset_done: assert property (@(posedge clk) $fell(rst) |-> done)
        else begin
            value_errors++;
            $display("[ERROR] %0t done expected 1 got %b", $time, $sampled(done));
        end

    reset_rdy: assert property (@(posedge clk) $fell(rst) |-> !output_rdy)
        else begin
            value_errors++;
            $display("[ERROR] %0t output_rdy expected 0 got %b", $time,
                     $sampled(output_rdy));
        end

    // result must match the model for every cycle it is offered
    result_value: assert property (@(posedge clk) disable iff (rst)
        output_rdy |-> data_out == exp_out)
        else begin
            value_errors++;
            $display("[ERROR] %0t data_out expected %h got %h", $time,
                     $sampled(exp_out), $sampled(data_out));
        end

    done_with_rdy: assert property (@(posedge clk) disable iff (rst)
        $rose(output_rdy) |-> $rose(done))
        else begin
            value_errors++;
            $display("[ERROR] %0t done expected rise got %b", $time, $sampled(done));
        end

    hold_rdy: assert property (@(posedge clk) disable iff (rst)
        output_rdy && !output_ack |=> output_rdy)
        else begin
            value_errors++;
            $display("[ERROR] %0t output_rdy expected 1 got %b", $time,
                     $sampled(output_rdy));
        end

    // a start while the result waits must not begin a run
    hold_done: assert property (@(posedge clk) disable iff (rst)
        output_rdy && !output_ack |=> done)
        else begin
            value_errors++;
            $display("[ERROR] %0t done expected 1 got %b", $time, $sampled(done));
        end

    ack_clears: assert property (@(posedge clk) disable iff (rst)
        output_rdy && output_ack |=> !output_rdy)
        else begin
            value_errors++;
            $display("[ERROR] %0t output_rdy expected 0 got %b", $time,
                     $sampled(output_rdy));
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic randomize_weights();
        foreach (w_lin[i]) w_lin[i] = ffn_pkg::data_t'($urandom);
        foreach (w_ff1[i]) w_ff1[i] = ffn_pkg::data_t'($urandom);
        foreach (w_ff2[i]) w_ff2[i] = ffn_pkg::data_t'($urandom);
    endtask

    task automatic set_vectors(input logic neg_res);
        for (int i = 0; i < ffn_pkg::X_DIM; i++) begin
            x_vec[i] = ffn_pkg::data_t'($urandom);
            if (neg_res) begin
                r_vec[i] = ffn_pkg::data_t'(-1 - int'($urandom_range(127, 0)));
            end else begin
                r_vec[i] = ffn_pkg::data_t'($urandom);
            end
            x_in[i*ffn_pkg::DATA_W +: ffn_pkg::DATA_W]   = x_vec[i];
            res_in[i*ffn_pkg::DATA_W +: ffn_pkg::DATA_W] = r_vec[i];
        end
        exp_out = model_out();
    endtask

    // start one run, optionally try host writes while busy, then acknowledge
    task automatic run_and_check(input logic poke_busy);
        int n;
        int hold;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (done && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (done) begin
            timeout_errors++;
            $display("timeout: done never fell after start at %0t", $time);
        end
        if (poke_busy) begin
            write_weight(ffn_pkg::MEM_SEL_LIN, 0, ~w_lin[0]);
            write_weight(ffn_pkg::MEM_SEL_FF2, ffn_pkg::FF2_DEPTH - 1,
                         ~w_ff2[ffn_pkg::FF2_DEPTH-1]);
        end
        n = 0;
        while (!done && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            timeout_errors++;
            $display("timeout: run did not finish by %0t", $time);
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        hold = $urandom_range(4, 0);
        repeat (hold) @(negedge clk);
        output_ack = 1'b1;
        @(negedge clk);
        output_ack = 1'b0;
    endtask

    initial begin
        int run;
        void'($urandom(32'hc05790d7));
        clk            = 1'b0;
        rst            = 1'b1;
        start          = 1'b0;
        x_in           = '0;
        res_in         = '0;
        mem_sel        = '0;
        mem_wr         = 1'b0;
        mem_addr       = '0;
        mem_data       = '0;
        output_ack     = 1'b0;
        exp_out        = '0;
        value_errors   = 0;
        timeout_errors = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        randomize_weights();
        load_weights();
        set_vectors(1'b0);
        run_and_check(1'b0);

        // zero weights, so only the residual path carries a value
        foreach (w_lin[i]) w_lin[i] = '0;
        foreach (w_ff1[i]) w_ff1[i] = '0;
        foreach (w_ff2[i]) w_ff2[i] = '0;
        load_weights();
        set_vectors(1'b1);
        run_and_check(1'b0);

        // unknown select codes and busy writes must not touch the RAMs
        randomize_weights();
        load_weights();
        write_weight(3'd0, 0, ~w_lin[0]);
        write_weight(3'd6, 1, ~w_ff1[1]);
        write_weight(3'd7, 2, ~w_ff2[2]);
        set_vectors(1'b0);
        run_and_check(1'b1);

        for (run = 0; run < B2B_RUNS; run++) begin
            set_vectors(1'b0);
            run_and_check(1'b0);
        end

        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
